//--- tb.f
verilog/gpr_pkg.sv
verilog/gpr_lane_bank.sv
verilog/clone_sequencer.sv
verilog/primary_warp_context.sv
verilog/spawned_warp_context.sv
verilog/operand_select.sv
verilog/gpr_wrapper.sv
dv/tb_gpr_wrapper.sv

//--- Bender.yml
package:
  name: gpr_wrapper

sources:
  - verilog/gpr_pkg.sv
  - verilog/gpr_lane_bank.sv
  - verilog/clone_sequencer.sv
  - verilog/primary_warp_context.sv
  - verilog/spawned_warp_context.sv
  - verilog/operand_select.sv
  - verilog/gpr_wrapper.sv
  - target: simulation
    files:
      - dv/tb_gpr_wrapper.sv

//--- dv/tb_gpr_wrapper.sv
`timescale 1ns/100ps

module tb_gpr_wrapper import gpr_pkg::*; ();

	localparam int STALL_TIMEOUT = 64;
	localparam logic [WB_BITS-1:0] WB_WRITE = 2'd1;

	logic                                 clk;
	logic                                 reset;
	logic [WARP_BITS-1:0]                 warp_num;
	logic [REG_ADDR_BITS-1:0]             rs1;
	logic [REG_ADDR_BITS-1:0]             rs2;
	logic                                 src1_fwd;
	logic                                 src2_fwd;
	logic [NUM_THREADS-1:0][REG_BITS-1:0] src1_fwd_data;
	logic [NUM_THREADS-1:0][REG_BITS-1:0] src2_fwd_data;
	logic                                 wb_valid;
	logic [WB_BITS-1:0]                   wb;
	logic [WARP_BITS-1:0]                 wb_warp_num;
	logic [REG_ADDR_BITS-1:0]             rd;
	logic [NUM_THREADS-1:0][REG_BITS-1:0] write_data;
	logic                                 is_jal;
	logic [REG_BITS-1:0]                  curr_pc;
	logic                                 is_clone;
	logic [WARP_BITS-1:0]                 clone_warp_num;
	logic                                 is_wspawn;
	logic [WARP_BITS-1:0]                 wspawn_warp_num;
	logic [NUM_THREADS-1:0][REG_BITS-1:0] a_reg_data;
	logic [NUM_THREADS-1:0][REG_BITS-1:0] b_reg_data;
	logic                                 clone_stall;

	logic [REG_BITS-1:0] model [NUM_WARPS][NUM_THREADS][NUM_REGS]; // Expected register state
	logic [31:0]         lfsr_state;
	int                  lane_errors;
	int                  flag_errors;
	int                  timeout_errors;

	gpr_wrapper i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ########################################################################
	// Helpers and compare tasks
	// ########################################################################

	function automatic logic [31:0] next_random(input int nbits);
		logic [31:0] value;
		logic        out_bit;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			out_bit    = lfsr_state[0]; // Galois form, one step per bit
			lfsr_state = lfsr_state >> 1;
			if (out_bit) begin
				lfsr_state ^= 32'hA3000000;
			end
			value = {value[30:0], out_bit};
		end
		return value;
	endfunction

	function automatic logic [NUM_THREADS-1:0][REG_BITS-1:0] random_lanes();
		logic [NUM_THREADS-1:0][REG_BITS-1:0] lanes;
		for (int t = 0; t < NUM_THREADS; t++) begin
			lanes[t] = next_random(REG_BITS);
		end
		return lanes;
	endfunction

	function automatic logic [NUM_THREADS-1:0][REG_BITS-1:0] model_lanes(input int w, input int r);
		logic [NUM_THREADS-1:0][REG_BITS-1:0] lanes;
		for (int t = 0; t < NUM_THREADS; t++) begin
			lanes[t] = (r == 0) ? '0 : model[w][t][r];
		end
		return lanes;
	endfunction

	task automatic check_lanes(input logic [NUM_THREADS-1:0][REG_BITS-1:0] got,
			input logic [NUM_THREADS-1:0][REG_BITS-1:0] exp, input string what);
		if (got !== exp) begin
			lane_errors++;
			$display("[FAIL] %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			flag_errors++;
			$display("[FAIL] %0t: %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic read_check(input int w, input int r1, input int r2);
		@(posedge clk);
		warp_num <= WARP_BITS'(w);
		rs1      <= REG_ADDR_BITS'(r1);
		rs2      <= REG_ADDR_BITS'(r2);
		@(negedge clk);
		check_lanes(a_reg_data, model_lanes(w, r1), $sformatf("warp %0d a x%0d", w, r1));
		check_lanes(b_reg_data, model_lanes(w, r2), $sformatf("warp %0d b x%0d", w, r2));
	endtask

	task automatic check_all_regs();
		for (int w = 0; w < NUM_WARPS; w++) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				read_check(w, r, (r + 11) % NUM_REGS);
			end
		end
	endtask

	// Drives one writeback, then reads the same register on the following cycle
	task automatic writeback_and_read(input int w, input int r, input logic valid,
			input logic [WB_BITS-1:0] code, input logic [NUM_THREADS-1:0][REG_BITS-1:0] data);
		@(posedge clk);
		wb_valid    <= valid;
		wb          <= code;
		wb_warp_num <= WARP_BITS'(w);
		rd          <= REG_ADDR_BITS'(r);
		write_data  <= data;
		@(posedge clk);
		wb_valid <= 1'b0;
		wb       <= WB_NONE;
		warp_num <= WARP_BITS'(w);
		rs1      <= REG_ADDR_BITS'(r);
		rs2      <= REG_ADDR_BITS'(r);
		if (valid && code != WB_NONE && r != 0) begin
			for (int t = 0; t < NUM_THREADS; t++) begin
				model[w][t][r] = data[t];
			end
		end
		@(negedge clk);
		check_lanes(a_reg_data, model_lanes(w, r), $sformatf("warp %0d a x%0d after wb", w, r));
		check_lanes(b_reg_data, model_lanes(w, r), $sformatf("warp %0d b x%0d after wb", w, r));
	endtask

	// ########################################################################
	// Tests
	// ########################################################################

	task automatic test_reset_state();
		@(negedge clk);
		check_flag(clone_stall, 1'b0, "clone_stall after reset");
		check_all_regs();
	endtask

	task automatic test_random_writes();
		for (int w = 0; w < NUM_WARPS; w++) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				writeback_and_read(w, r, 1'b1, WB_BITS'(1 + next_random(2) % 3), random_lanes());
			end
		end
		check_all_regs();
	endtask

	task automatic test_blocked_writes();
		repeat (16) begin
			if (next_random(1)) begin
				writeback_and_read(next_random(WARP_BITS), next_random(REG_ADDR_BITS), 1'b1,
					WB_NONE, random_lanes());
			end else begin
				writeback_and_read(next_random(WARP_BITS), next_random(REG_ADDR_BITS), 1'b0,
					WB_WRITE, random_lanes());
			end
		end
		check_all_regs();
	endtask

	task automatic test_forwarding();
		int                                   w;
		int                                   r1;
		int                                   r2;
		logic                                 f1;
		logic                                 f2;
		logic                                 jal;
		logic [REG_BITS-1:0]                  pc;
		logic [NUM_THREADS-1:0][REG_BITS-1:0] d1;
		logic [NUM_THREADS-1:0][REG_BITS-1:0] d2;
		repeat (24) begin
			w   = next_random(WARP_BITS);
			r1  = next_random(REG_ADDR_BITS);
			r2  = next_random(REG_ADDR_BITS);
			f1  = next_random(1);
			f2  = next_random(1);
			jal = next_random(1);
			pc  = next_random(REG_BITS);
			d1  = random_lanes();
			d2  = random_lanes();
			@(posedge clk);
			warp_num      <= WARP_BITS'(w);
			rs1           <= REG_ADDR_BITS'(r1);
			rs2           <= REG_ADDR_BITS'(r2);
			src1_fwd      <= f1;
			src1_fwd_data <= d1;
			src2_fwd      <= f2;
			src2_fwd_data <= d2;
			is_jal        <= jal;
			curr_pc       <= pc;
			@(negedge clk);
			check_lanes(a_reg_data, jal ? {NUM_THREADS{pc}} : (f1 ? d1 : model_lanes(w, r1)),
				$sformatf("source a, fwd %b jal %b", f1, jal));
			check_lanes(b_reg_data, f2 ? d2 : model_lanes(w, r2),
				$sformatf("source b, fwd %b", f2));
		end
		@(posedge clk);
		src1_fwd <= 1'b0;
		src2_fwd <= 1'b0;
		is_jal   <= 1'b0;
	endtask

	task automatic test_spawn(input int r);
		@(posedge clk);
		is_wspawn       <= 1'b1;
		wspawn_warp_num <= WARP_BITS'(r);
		@(posedge clk);
		is_wspawn <= 1'b0;
		warp_num  <= WARP_BITS'(r);
		rs1       <= REG_ADDR_BITS'(1);
		rs2       <= REG_ADDR_BITS'(NUM_REGS - 1);
		for (int k = 1; k < NUM_REGS; k++) begin
			model[r][0][k] = model[0][0][k];
		end
		@(negedge clk);
		check_lanes(a_reg_data, model_lanes(r, 1), $sformatf("warp %0d a x1 after spawn", r));
		check_lanes(b_reg_data, model_lanes(r, NUM_REGS - 1),
			$sformatf("warp %0d b x%0d after spawn", r, NUM_REGS - 1));
		check_all_regs();
	endtask

	task automatic test_clone(input int w);
		int stall_cycles;
		@(posedge clk);
		is_clone       <= 1'b1;
		clone_warp_num <= WARP_BITS'(w);
		@(posedge clk);
		is_clone <= 1'b0;
		@(negedge clk);
		check_flag(clone_stall, 1'b1,
			$sformatf("clone_stall one cycle after clone of warp %0d", w));
		stall_cycles = 0;
		while (clone_stall && stall_cycles < STALL_TIMEOUT) begin
			stall_cycles++;
			@(negedge clk);
		end
		if (clone_stall) begin
			timeout_errors++;
			$display("Timeout: clone_stall is still high after %0d cycles", STALL_TIMEOUT);
		end else begin
			check_flag(stall_cycles == NUM_REGS, 1'b1,
				$sformatf("clone stall of warp %0d lasted %0d cycles", w, stall_cycles));
		end
		for (int t = 1; t < NUM_THREADS; t++) begin
			for (int k = 0; k < NUM_REGS; k++) begin
				model[w][t][k] = model[w][0][k];
			end
		end
		check_all_regs();
	endtask

	initial begin
		lfsr_state     = 32'h9ae4eb11;
		lane_errors    = 0;
		flag_errors    = 0;
		timeout_errors = 0;
		for (int w = 0; w < NUM_WARPS; w++) begin
			for (int t = 0; t < NUM_THREADS; t++) begin
				for (int k = 0; k < NUM_REGS; k++) begin
					model[w][t][k] = '0;
				end
			end
		end
		reset           = 1'b1;
		warp_num        = '0;
		rs1             = '0;
		rs2             = '0;
		src1_fwd        = 1'b0;
		src2_fwd        = 1'b0;
		src1_fwd_data   = '0;
		src2_fwd_data   = '0;
		wb_valid        = 1'b0;
		wb              = WB_NONE;
		wb_warp_num     = '0;
		rd              = '0;
		write_data      = '0;
		is_jal          = 1'b0;
		curr_pc         = '0;
		is_clone        = 1'b0;
		clone_warp_num  = '0;
		is_wspawn       = 1'b0;
		wspawn_warp_num = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		test_reset_state();
		test_random_writes();
		test_blocked_writes();
		test_forwarding();
		test_spawn(1);
		test_spawn(3);
		test_clone(2);
		test_clone(0); // Warp 0 is also the spawn source

		$display("Error counts: lanes %0d, flags %0d, timeouts %0d",
			lane_errors, flag_errors, timeout_errors);
		if (lane_errors == 0 && flag_errors == 0 && timeout_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/gpr_wrapper.sv
`timescale 1ns/100ps

module gpr_wrapper import gpr_pkg::*; (
	input  logic                                  clk,
	input  logic                                  reset,

	input  logic [WARP_BITS-1:0]                  warp_num,
	input  logic [REG_ADDR_BITS-1:0]              rs1,
	input  logic [REG_ADDR_BITS-1:0]              rs2,

	input  logic                                  src1_fwd,
	input  logic [NUM_THREADS-1:0][REG_BITS-1:0] src1_fwd_data,
	input  logic                                  src2_fwd,
	input  logic [NUM_THREADS-1:0][REG_BITS-1:0] src2_fwd_data,

	input  logic                                  wb_valid,
	input  logic [WB_BITS-1:0]                    wb,
	input  logic [WARP_BITS-1:0]                  wb_warp_num,
	input  logic [REG_ADDR_BITS-1:0]              rd,
	input  logic [NUM_THREADS-1:0][REG_BITS-1:0] write_data,

	input  logic                                  is_jal,
	input  logic [REG_BITS-1:0]                   curr_pc,

	input  logic                                  is_clone,
	input  logic [WARP_BITS-1:0]                  clone_warp_num,

	input  logic                                  is_wspawn,
	input  logic [WARP_BITS-1:0]                  wspawn_warp_num,

	output logic [NUM_THREADS-1:0][REG_BITS-1:0] a_reg_data,
	output logic [NUM_THREADS-1:0][REG_BITS-1:0] b_reg_data,
	output logic                                  clone_stall
);

	logic [NUM_WARPS-1:0] warp_sel;
	logic [NUM_WARPS-1:0] wb_sel;
	logic [NUM_WARPS-1:0] clone_start;
	logic [NUM_WARPS-1:1] spawn_sel; // Warp 0 cannot be spawned
	logic                 write_register;

	logic [NUM_WARPS-1:0][NUM_THREADS-1:0][REG_BITS-1:0] ctx_a_data;
	logic [NUM_WARPS-1:0][NUM_THREADS-1:0][REG_BITS-1:0] ctx_b_data;
	logic [NUM_WARPS-1:0]                                 ctx_stall;
	logic [NUM_REGS-1:0][REG_BITS-1:0]                    lane0_regs;

	// ########################################################################
	// Select and write decode
	// ########################################################################

	assign write_register = (wb != WB_NONE) && wb_valid;

	for (genvar w = 0; w < NUM_WARPS; w++) begin : g_decode
		assign warp_sel[w]    = (warp_num == WARP_BITS'(w));
		assign wb_sel[w]      = write_register && (wb_warp_num == WARP_BITS'(w));
		assign clone_start[w] = is_clone && (clone_warp_num == WARP_BITS'(w));
		if (w > 0) begin : g_spawn
			assign spawn_sel[w] = is_wspawn && (wspawn_warp_num == WARP_BITS'(w));
		end
	end

	// ########################################################################
	// Warp contexts
	// ########################################################################

	primary_warp_context i_ctx_zero (
		.clk        (clk),
		.reset      (reset),
		.rs1        (rs1),
		.rs2        (rs2),
		.write_en   (wb_sel[0]),
		.rd         (rd),
		.write_data (write_data),
		.clone_start(clone_start[0]),
		.a_data     (ctx_a_data[0]),
		.b_data     (ctx_b_data[0]),
		.stall      (ctx_stall[0]),
		.lane0_regs (lane0_regs)
	);

	for (genvar r = 1; r < NUM_WARPS; r++) begin : g_ctx
		spawned_warp_context i_ctx (
			.clk        (clk),
			.reset      (reset),
			.rs1        (rs1),
			.rs2        (rs2),
			.write_en   (wb_sel[r]),
			.rd         (rd),
			.write_data (write_data),
			.clone_start(clone_start[r]),
			.wspawn     (spawn_sel[r]),
			.spawn_regs (lane0_regs),
			.a_data     (ctx_a_data[r]),
			.b_data     (ctx_b_data[r]),
			.stall      (ctx_stall[r])
		);
	end

	operand_select i_operand_select (
		.warp_sel     (warp_sel),
		.ctx_a_data   (ctx_a_data),
		.ctx_b_data   (ctx_b_data),
		.ctx_stall    (ctx_stall),
		.src1_fwd     (src1_fwd),
		.src1_fwd_data(src1_fwd_data),
		.src2_fwd     (src2_fwd),
		.src2_fwd_data(src2_fwd_data),
		.is_jal       (is_jal),
		.curr_pc      (curr_pc),
		.a_reg_data   (a_reg_data),
		.b_reg_data   (b_reg_data),
		.clone_stall  (clone_stall)
	);

endmodule

//--- verilog/operand_select.sv
`timescale 1ns/100ps

module operand_select import gpr_pkg::*; (
	input  logic [NUM_WARPS-1:0]                                 warp_sel,
	input  logic [NUM_WARPS-1:0][NUM_THREADS-1:0][REG_BITS-1:0] ctx_a_data,
	input  logic [NUM_WARPS-1:0][NUM_THREADS-1:0][REG_BITS-1:0] ctx_b_data,
	input  logic [NUM_WARPS-1:0]                                 ctx_stall,
	input  logic                                                 src1_fwd,
	input  logic [NUM_THREADS-1:0][REG_BITS-1:0]                src1_fwd_data,
	input  logic                                                 src2_fwd,
	input  logic [NUM_THREADS-1:0][REG_BITS-1:0]                src2_fwd_data,
	input  logic                                                 is_jal,
	input  logic [REG_BITS-1:0]                                  curr_pc,
	output logic [NUM_THREADS-1:0][REG_BITS-1:0]                a_reg_data,
	output logic [NUM_THREADS-1:0][REG_BITS-1:0]                b_reg_data,
	output logic                                                 clone_stall
);

	logic [NUM_THREADS-1:0][REG_BITS-1:0] sel_a;
	logic [NUM_THREADS-1:0][REG_BITS-1:0] sel_b;

	// And-or mux over the one-hot warp select
	always_comb begin
		sel_a = '0;
		sel_b = '0;
		for (int w = 0; w < NUM_WARPS; w++) begin
			sel_a |= ctx_a_data[w] & {(NUM_THREADS * REG_BITS){warp_sel[w]}};
			sel_b |= ctx_b_data[w] & {(NUM_THREADS * REG_BITS){warp_sel[w]}};
		end
	end

	// Jal beats forwarding on source A
	assign a_reg_data = is_jal   ? {NUM_THREADS{curr_pc}} :
	                    src1_fwd ? src1_fwd_data : sel_a;
	assign b_reg_data = src2_fwd ? src2_fwd_data : sel_b;

	assign clone_stall = |ctx_stall;

	// More than one active context would merge two warps' operands
	a_warp_sel_onehot: assert final ($isunknown(warp_sel) || $onehot(warp_sel))
		else $error("warp read select is not one-hot");

endmodule

//--- verilog/spawned_warp_context.sv
`timescale 1ns/100ps

module spawned_warp_context import gpr_pkg::*; (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [REG_ADDR_BITS-1:0]              rs1,
	input  logic [REG_ADDR_BITS-1:0]              rs2,
	input  logic                                  write_en,
	input  logic [REG_ADDR_BITS-1:0]              rd,
	input  logic [NUM_THREADS-1:0][REG_BITS-1:0] write_data,
	input  logic                                  clone_start,
	input  logic                                  wspawn,
	input  logic [NUM_REGS-1:0][REG_BITS-1:0]    spawn_regs,
	output logic [NUM_THREADS-1:0][REG_BITS-1:0] a_data,
	output logic [NUM_THREADS-1:0][REG_BITS-1:0] b_data,
	output logic                                  stall
);

	logic [NUM_THREADS-1:0][NUM_REGS-1:0][REG_BITS-1:0] lane_regs;

	logic                     copy_en;
	logic [REG_ADDR_BITS-1:0] copy_index;

	clone_sequencer i_clone_seq (
		.clk       (clk),
		.reset     (reset),
		.start     (clone_start),
		.busy      (stall),
		.copy_en   (copy_en),
		.copy_index(copy_index)
	);

	// ########################################################################
	// Lanes
	// ########################################################################

	for (genvar t = 0; t < NUM_THREADS; t++) begin : g_lane
		logic                              load_en;
		logic [NUM_REGS-1:0][REG_BITS-1:0] load_regs;

		if (t == 0) begin : g_spawn
			// A spawn takes over warp 0 lane 0 in a single edge
			assign load_en   = wspawn;
			assign load_regs = spawn_regs;
		end else begin : g_copy
			assign load_en = copy_en;

			always_comb begin
				load_regs             = lane_regs[t];
				load_regs[copy_index] = lane_regs[0][copy_index]; // Clone copy of one register
			end
		end

		gpr_lane_bank i_bank (
			.clk       (clk),
			.reset     (reset),
			.rs1       (rs1),
			.rs2       (rs2),
			.write_en  (write_en),
			.rd        (rd),
			.write_data(write_data[t]),
			.load_en   (load_en),
			.load_regs (load_regs),
			.rs1_data  (a_data[t]),
			.rs2_data  (b_data[t]),
			.regs      (lane_regs[t])
		);
	end

endmodule

//--- verilog/primary_warp_context.sv
`timescale 1ns/100ps

module primary_warp_context import gpr_pkg::*; (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [REG_ADDR_BITS-1:0]              rs1,
	input  logic [REG_ADDR_BITS-1:0]              rs2,
	input  logic                                  write_en,
	input  logic [REG_ADDR_BITS-1:0]              rd,
	input  logic [NUM_THREADS-1:0][REG_BITS-1:0] write_data,
	input  logic                                  clone_start,
	output logic [NUM_THREADS-1:0][REG_BITS-1:0] a_data,
	output logic [NUM_THREADS-1:0][REG_BITS-1:0] b_data,
	output logic                                  stall,
	output logic [NUM_REGS-1:0][REG_BITS-1:0]    lane0_regs
);

	logic [NUM_THREADS-1:0][NUM_REGS-1:0][REG_BITS-1:0] lane_regs;

	logic                     copy_en;
	logic [REG_ADDR_BITS-1:0] copy_index;

	clone_sequencer i_clone_seq (
		.clk       (clk),
		.reset     (reset),
		.start     (clone_start),
		.busy      (stall),
		.copy_en   (copy_en),
		.copy_index(copy_index)
	);

	// ########################################################################
	// Lanes
	// ########################################################################

	for (genvar t = 0; t < NUM_THREADS; t++) begin : g_lane
		logic                              load_en;
		logic [NUM_REGS-1:0][REG_BITS-1:0] load_regs;

		if (t == 0) begin : g_source
			// Lane 0 is the clone source and is never loaded here
			assign load_en   = 1'b0;
			assign load_regs = '0;
		end else begin : g_copy
			assign load_en = copy_en;

			// Own file with one entry replaced by lane 0's copy
			always_comb begin
				load_regs             = lane_regs[t];
				load_regs[copy_index] = lane_regs[0][copy_index];
			end
		end

		gpr_lane_bank i_bank (
			.clk       (clk),
			.reset     (reset),
			.rs1       (rs1),
			.rs2       (rs2),
			.write_en  (write_en),
			.rd        (rd),
			.write_data(write_data[t]),
			.load_en   (load_en),
			.load_regs (load_regs),
			.rs1_data  (a_data[t]),
			.rs2_data  (b_data[t]),
			.regs      (lane_regs[t])
		);
	end

	assign lane0_regs = lane_regs[0]; // Source file for every warp spawn

endmodule

//--- verilog/clone_sequencer.sv
`timescale 1ns/100ps

module clone_sequencer import gpr_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	output logic                     busy,
	output logic                     copy_en,
	output logic [REG_ADDR_BITS-1:0] copy_index
);

	logic [REG_ADDR_BITS-1:0] count;

	// Walks every register once, one per cycle, starting the cycle after start
	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (!busy) begin
			if (start) begin
				busy  <= 1'b1;
				count <= '0;
			end
		end else begin
			count <= count + 1'b1;
			if (count == REG_ADDR_BITS'(NUM_REGS - 1)) begin
				busy <= 1'b0; // Last register copied this cycle
			end
		end
	end

	assign copy_en    = busy;
	assign copy_index = count;

	// ########################################################################
	// Checks
	// ########################################################################

	// The pipeline must hold off further clones while the stall is up
	property p_no_clone_while_busy;
		@(posedge clk) disable iff (reset)
		busy |-> !start;
	endproperty

	a_no_clone_while_busy: assert property (p_no_clone_while_busy)
		else $error("clone request arrived while a clone was still running");

endmodule

//--- verilog/gpr_lane_bank.sv
`timescale 1ns/100ps

module gpr_lane_bank import gpr_pkg::*; (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [REG_ADDR_BITS-1:0]           rs1,
	input  logic [REG_ADDR_BITS-1:0]           rs2,
	input  logic                               write_en,
	input  logic [REG_ADDR_BITS-1:0]           rd,
	input  logic [REG_BITS-1:0]                write_data,
	input  logic                               load_en,
	input  logic [NUM_REGS-1:0][REG_BITS-1:0] load_regs,
	output logic [REG_BITS-1:0]                rs1_data,
	output logic [REG_BITS-1:0]                rs2_data,
	output logic [NUM_REGS-1:0][REG_BITS-1:0] regs
);

	logic [NUM_REGS-1:0][REG_BITS-1:0] next_regs;

	// A whole-file load is applied first so that a writeback in the same
	// cycle still lands on top of it
	always_comb begin
		next_regs = load_en ? load_regs : regs;
		if (write_en) begin
			next_regs[rd] = write_data;
		end
		next_regs[0] = '0; // Register 0 is hardwired to zero
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '0;
		end else begin
			regs <= next_regs;
		end
	end

	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

endmodule

//--- verilog/gpr_pkg.sv
package gpr_pkg;

	// ########################################################################
	// Core geometry
	// ########################################################################

	localparam int NUM_WARPS   = 4;
	localparam int NUM_THREADS = 2; // Lanes per warp
	localparam int NUM_REGS    = 32;
	localparam int REG_BITS    = 32;

	// Field widths derived from the geometry above
	localparam int WARP_BITS     = $clog2(NUM_WARPS);
	localparam int REG_ADDR_BITS = $clog2(NUM_REGS);

	// ########################################################################
	// Writeback codes
	// ########################################################################

	localparam int WB_BITS = 2;

	// Any other code means the result goes to rd
	localparam logic [WB_BITS-1:0] WB_NONE = 2'd0;

endpackage
